// ==== Makefile ====
# Verilator build and run of the hazard unit testbench

VERILATOR ?= verilator
TOP       ?= hazard_unit_tb
FILELIST  ?= hazard_unit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then \
		echo "test failed, see $(LOG)"; exit 1; \
	elif ! grep -q "Simulation PASSED" $(LOG); then \
		echo "test failed, no result in $(LOG)"; exit 1; \
	else \
		echo "test passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/hazard_input.txt ====
# instr | id_ex rs1 rs2 rd mem_read | ex_mem rd rs2 load_rf mem_write | mem_wb rd load_rf
# strobes ir ir_resp dr dw d_resp | exp rs1_sel rs2_sel wdata_sel | exp stall pc..inst_stall
00000013  0 0 0 0  0 0 0 0  0 0  00100  0 0 0  0000000
00000013  0 0 0 0  0 0 0 0  0 0  00101  0 0 0  0000000
00000013  0 0 0 0  0 0 0 0  0 0  11000  0 0 0  0000000
00000013  5 5 0 0  5 0 1 0  5 1  11000  1 1 0  0000000
00000013  5 5 0 0  6 0 1 0  5 1  11000  2 2 0  0000000
00000013  0 0 0 0  0 0 1 0  0 1  11000  0 0 0  0000000
00000013  5 7 0 0  5 0 0 0  5 1  11000  2 0 0  0000000
00000013  5 7 0 0  7 0 1 0  5 1  11000  2 1 0  0000000
00000013  1 2 3 0  0 9 0 1  9 1  11000  0 0 1  0000000
00000013  1 2 3 0  0 9 0 1  9 0  11000  0 0 0  0000000
00000013  1 2 3 0  0 0 0 1  0 1  11000  0 0 0  0000000
002081b3  4 4 2 1  0 0 0 0  0 0  11000  0 0 0  1100010
002081b3  4 4 1 1  0 0 0 0  0 0  11000  0 0 0  1100010
00742023  4 4 7 1  0 0 0 0  0 0  11000  0 0 0  0000000
0074a023  4 4 9 1  0 0 0 0  0 0  11000  0 0 0  1100010
00730293  4 4 7 1  0 0 0 0  0 0  11000  0 0 0  0000000
00730293  4 4 6 1  0 0 0 0  0 0  11000  0 0 0  1100010
12345237  4 4 8 1  0 0 0 0  0 0  11000  0 0 0  0000000
002081b3  4 4 2 0  0 0 0 0  0 0  11000  0 0 0  0000000
00000013  0 0 0 0  0 0 0 0  0 0  10000  0 0 0  1111101
002081b3  4 4 1 1  0 0 0 0  0 0  10000  0 0 0  1111101
002081b3  4 4 1 1  0 0 0 0  0 0  11000  0 0 0  1100010
00000013  0 0 0 0  0 0 0 0  0 0  11100  0 0 0  0000000
00000013  0 0 0 0  0 0 0 0  0 0  11000  0 0 0  0000000
00000013  0 0 0 0  0 0 0 0  0 0  11100  0 0 0  0000000
00000013  0 0 0 0  0 0 0 0  0 0  11100  0 0 0  1111100
00000013  0 0 0 0  0 0 0 0  0 0  11100  0 0 0  1111100
00000013  0 0 0 0  0 0 0 0  0 0  11101  0 0 0  0000000
00000013  0 0 0 0  0 0 0 0  0 0  11010  0 0 0  0000000
00000013  0 0 0 0  0 0 0 0  0 0  11010  0 0 0  1111100
00000013  0 0 0 0  0 0 0 0  0 0  11011  0 0 0  0000000

// ==== bench/hazard_unit_props.sv ====
// Hazard unit output properties
module hazard_unit_props (
	input logic                    clk,
	input logic                    rst_n,
	input hazard_pkg::id_ex_ctl_t  id_ex,
	input hazard_pkg::ex_mem_ctl_t ex_mem,
	input hazard_pkg::mem_wb_ctl_t mem_wb,
	input hazard_pkg::mem_port_t   mem,
	input hazard_pkg::fwd_sel_t    fwd,
	input hazard_pkg::stall_vec_t  stall
);
	timeunit 1ns;
	timeprecision 1ps;

	import rv32i_pkg::*;
	import hazard_pkg::*;

	// one sticky flag per property
	logic bubble_bad = 1'b0;
	logic fetch_bad  = 1'b0;
	logic x0_bad     = 1'b0;
	logic reset_bad  = 1'b0;
	logic fail_seen;
	// a later stage selected although its rd is x0
	logic x0_select;

	assign fail_seen = bubble_bad | fetch_bad | x0_bad | reset_bad;

	assign x0_select =
		((fwd.rs1_sel == from_ex_mem || fwd.rs2_sel == from_ex_mem) && ex_mem.rd == zero_reg) ||
		((fwd.rs1_sel == from_mem_wb || fwd.rs2_sel == from_mem_wb) && mem_wb.rd == zero_reg) ||
		(fwd.wdata_sel == wdata_mem_wb && mem_wb.rd == zero_reg);

	// a bubble must never land on a frozen ID/EX
	bubble_vs_hold: assert property (@(posedge clk) disable iff (!rst_n)
		!(stall.bubble && stall.id_ex))
	else begin
		$error("bubble raised while ID/EX is held");
		bubble_bad = 1'b1;
	end

	// fetch miss holds pc and IF/ID
	fetch_hold: assert property (@(posedge clk) disable iff (!rst_n)
		stall.inst_stall |-> (stall.pc && stall.if_id))
	else begin
		$error("inst_stall without pc and if_id held");
		fetch_bad = 1'b1;
	end

	x0_never_forwarded: assert property (@(posedge clk) disable iff (!rst_n)
		!x0_select)
	else begin
		$error("forward select points at a stage writing x0");
		x0_bad = 1'b1;
	end

	// cleared delay flops, so nothing stalls right after reset
	reset_quiet: assert property (@(posedge clk)
		($rose(rst_n) && !mem.inst_read && !id_ex.mem_read) |-> (stall == '0))
	else begin
		$error("stall line active in the first cycle after reset");
		reset_bad = 1'b1;
	end

endmodule : hazard_unit_props

// ==== bench/hazard_unit_tb.sv ====
// Hazard unit testbench
module hazard_unit_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import rv32i_pkg::*;
	import hazard_pkg::*;

	localparam int    clk_period    = 40;
	localparam int    reset_cycles  = 2;
	// slack on top of the vector run
	localparam int    margin_cycles = 10;
	localparam string vector_file   = "bench/hazard_input.txt";

	// one line of the vector file, inputs then expected outputs
	typedef struct packed {
		instr_t      instr;
		id_ex_ctl_t  id_ex;
		ex_mem_ctl_t ex_mem;
		mem_wb_ctl_t mem_wb;
		mem_port_t   mem;
		fwd_sel_t    fwd;
		stall_vec_t  stall;
	} vector_t;

	logic        clk;
	logic        rst_n;
	instr_t      if_id_instr;
	id_ex_ctl_t  id_ex;
	ex_mem_ctl_t ex_mem;
	mem_wb_ctl_t mem_wb;
	mem_port_t   mem;
	fwd_sel_t    fwd;
	stall_vec_t  stall;
	vector_t     vectors[$];
	bit          loaded = 1'b0;

	tb_clock #(.period_ns(clk_period)) u_clock (.clk(clk));

	hazard_unit UUT (
		.clk         (clk),
		.rst_n       (rst_n),
		.if_id_instr (if_id_instr),
		.id_ex       (id_ex),
		.ex_mem      (ex_mem),
		.mem_wb      (mem_wb),
		.mem         (mem),
		.fwd         (fwd),
		.stall       (stall)
	);

	bind hazard_unit hazard_unit_props u_props (
		.clk    (clk),
		.rst_n  (rst_n),
		.id_ex  (id_ex),
		.ex_mem (ex_mem),
		.mem_wb (mem_wb),
		.mem    (mem),
		.fwd    (fwd),
		.stall  (stall)
	);

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("** Error at %0t ns: %s expected %0h, got %0h", $time, name, expected,
				actual);
			$display("Simulation FAILED");
			$fatal(1, "output mismatch");
		end
	endtask

	// lines starting with # are column notes
	task automatic load_vectors();
		int          fd;
		int          fields;
		int          f[13];
		string       line;
		logic [31:0] word;
		logic [4:0]  strobes;
		logic [6:0]  exp_stall;
		vector_t     v;
		fd = $fopen(vector_file, "r");
		if (fd == 0) begin
			$display("could not open the vector file %s", vector_file);
			$display("Simulation FAILED");
			$fatal(1, "no stimulus");
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 8 || line[0] == "#") continue;
			fields = $sscanf(line, "%h %d %d %d %d %d %d %d %d %d %d %b %d %d %d %b", word,
				f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], strobes,
				f[10], f[11], f[12], exp_stall);
			if (fields != 16) begin
				$display("malformed line in the vector file: %s", line);
				$display("Simulation FAILED");
				$fatal(1, "bad stimulus");
			end
			v.instr  = word;
			v.id_ex  = {f[0][4:0], f[1][4:0], f[2][4:0], f[3][0]};
			v.ex_mem = {f[4][4:0], f[5][4:0], f[6][0], f[7][0]};
			v.mem_wb = {f[8][4:0], f[9][0]};
			v.mem    = strobes;
			v.fwd    = {f[10][1:0], f[11][1:0], f[12][0]};
			v.stall  = exp_stall;
			vectors.push_back(v);
		end
		$fclose(fd);
	endtask

	// budget grows with the vector count
	initial begin : watchdog
		wait (loaded);
		#((vectors.size() + reset_cycles + margin_cycles) * clk_period);
		$display("timeout, the vectors did not finish in the expected run time");
		$display("Simulation FAILED");
		$fatal(1, "watchdog expired");
	end

	// bound property failure ends the run
	initial begin : property_watch
		wait (UUT.u_props.fail_seen);
		$display("a bound property on the DUT outputs failed");
		$display("Simulation FAILED");
		$fatal(1, "property failure");
	end

	initial begin : stimulus
		rst_n       = 1'b0;
		if_id_instr = 32'h0000_0013;
		id_ex       = '0;
		ex_mem      = '0;
		mem_wb      = '0;
		// read held through reset, first vector keeps it up
		mem         = 5'b00100;
		load_vectors();
		loaded = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		foreach (vectors[i]) begin
			@(negedge clk);
			// reset ends together with the first vector
			rst_n       = 1'b1;
			if_id_instr = vectors[i].instr;
			id_ex       = vectors[i].id_ex;
			ex_mem      = vectors[i].ex_mem;
			mem_wb      = vectors[i].mem_wb;
			mem         = vectors[i].mem;
			// settled values just ahead of the rising edge
			#(clk_period / 2 - 5);
			check_value("fwd.rs1_sel", 32'(vectors[i].fwd.rs1_sel), 32'(fwd.rs1_sel));
			check_value("fwd.rs2_sel", 32'(vectors[i].fwd.rs2_sel), 32'(fwd.rs2_sel));
			check_value("fwd.wdata_sel", 32'(vectors[i].fwd.wdata_sel), 32'(fwd.wdata_sel));
			check_value("stall", 32'(vectors[i].stall), 32'(stall));
		end
		// let the properties see the last vector
		@(posedge clk);
		#1;
		if (UUT.u_props.fail_seen) begin
			$display("Simulation FAILED");
			$fatal(1, "property failure");
		end else begin
			$display("Simulation PASSED");
			$finish;
		end
	end

endmodule : hazard_unit_tb

// ==== bench/tb_clock.sv ====
// Testbench clock source
module tb_clock #(
	parameter int period_ns = 40
) (
	output logic clk
);
	timeunit 1ns;
	timeprecision 1ps;

	// free running, low for the first half period
	initial begin
		clk = 1'b0;
		forever #(period_ns / 2) clk = ~clk;
	end

endmodule : tb_clock

// ==== hazard_unit.f ====
hdl/rv32i_pkg.sv
hdl/hazard_pkg.sv
hdl/if_id_decode.sv
hdl/operand_forward.sv
hdl/stall_detect.sv
hdl/stall_control.sv
hdl/hazard_unit.sv
bench/tb_clock.sv
bench/hazard_unit_props.sv
bench/hazard_unit_tb.sv

// ==== hdl/hazard_pkg.sv ====
// Pipeline hazard control types
package hazard_pkg;

	// control bits captured in the ID/EX register
	typedef struct packed {
		rv32i_pkg::reg_idx_t rs1;
		rv32i_pkg::reg_idx_t rs2;
		rv32i_pkg::reg_idx_t rd;
		logic                mem_read;
	} id_ex_ctl_t;

	// control bits captured in the EX/MEM register
	typedef struct packed {
		rv32i_pkg::reg_idx_t rd;
		rv32i_pkg::reg_idx_t rs2;
		logic                load_regfile;
		logic                mem_write;
	} ex_mem_ctl_t;

	// control bits captured in the MEM/WB register
	typedef struct packed {
		rv32i_pkg::reg_idx_t rd;
		logic                load_regfile;
	} mem_wb_ctl_t;

	// instruction and data memory strobes
	typedef struct packed {
		logic inst_read;
		logic inst_resp;
		logic data_read;
		logic data_write;
		logic data_resp;
	} mem_port_t;

	// decoded IF/ID sources
	typedef struct packed {
		rv32i_pkg::reg_idx_t rs1;
		rv32i_pkg::reg_idx_t rs2;
		logic                rs1_used;
		logic                rs2_used;
		logic                is_store;
	} src_use_t;

	// ALU operand mux selects
	typedef enum logic [1:0] {
		from_regfile = 2'b00,
		from_ex_mem  = 2'b01,
		from_mem_wb  = 2'b10
	} fwd_src_t;

	// store data mux select
	typedef enum logic {
		wdata_regfile = 1'b0,
		wdata_mem_wb  = 1'b1
	} wdata_src_t;

	typedef struct packed {
		fwd_src_t   rs1_sel;
		fwd_src_t   rs2_sel;
		wdata_src_t wdata_sel;
	} fwd_sel_t;

	// reasons to hold the pipeline
	typedef struct packed {
		logic mem_stall;
		logic inst_stall;
		logic load_use;
	} stall_cause_t;

	// per-stage hold lines toward the datapath
	typedef struct packed {
		logic pc;
		logic if_id;
		logic id_ex;
		logic ex_mem;
		logic mem_wb;
		logic bubble;
		logic inst_stall;
	} stall_vec_t;

endpackage : hazard_pkg

// ==== hdl/hazard_unit.sv ====
// Hazard and forwarding unit
module hazard_unit (
	input  logic                    clk,
	input  logic                    rst_n,
	// raw word in the IF/ID register
	input  rv32i_pkg::instr_t       if_id_instr,
	// stage register control fields
	input  hazard_pkg::id_ex_ctl_t  id_ex,
	input  hazard_pkg::ex_mem_ctl_t ex_mem,
	input  hazard_pkg::mem_wb_ctl_t mem_wb,
	// memory request and response strobes
	input  hazard_pkg::mem_port_t   mem,
	// datapath mux selects
	output hazard_pkg::fwd_sel_t    fwd,
	// stage hold lines
	output hazard_pkg::stall_vec_t  stall
);

	import hazard_pkg::*;

	// decoded IF/ID sources
	src_use_t     src;
	// raw stall reasons
	stall_cause_t cause;

	// sources and use flags of the instruction in decode
	if_id_decode u_decode (
		.instr (if_id_instr),
		.src   (src)
	);

	// operand and store data selects for EX and MEM
	operand_forward u_forward (
		.id_ex  (id_ex),
		.ex_mem (ex_mem),
		.mem_wb (mem_wb),
		.fwd    (fwd)
	);

	// memory misses and load-use
	stall_detect u_detect (
		.clk   (clk),
		.rst_n (rst_n),
		.src   (src),
		.id_ex (id_ex),
		.mem   (mem),
		.cause (cause)
	);

	// causes onto stage lines
	stall_control u_control (
		.cause (cause),
		.stall (stall)
	);

endmodule : hazard_unit

// ==== hdl/if_id_decode.sv ====
// IF/ID source decoder
module if_id_decode (
	input  rv32i_pkg::instr_t   instr,
	output hazard_pkg::src_use_t src
);

	import rv32i_pkg::*;

	opcode_t opcode;
	logic    store;

	// opcode sits at the same bits in both views
	assign opcode = instr.r.opcode;
	assign store  = (opcode == op_store);

	// source use flags
	// only real reads may raise a load-use stall
	always_comb begin
		// rs1 and rs2 occupy the same slots in the R and S layouts
		src.rs1      = instr.r.rs1;
		src.rs2      = instr.r.rs2;
		src.is_store = store;
		// rs1 is read by everything but the upper-immediate and jal forms
		case (opcode)
			op_lui, op_auipc, op_jal: src.rs1_used = 1'b0;
			default:                  src.rs1_used = 1'b1;
		endcase
		// rs2 field holds immediate bits in i-type and friends
		case (opcode)
			op_reg, op_store, op_branch: src.rs2_used = 1'b1;
			default:                     src.rs2_used = 1'b0;
		endcase
	end

endmodule : if_id_decode

// ==== hdl/operand_forward.sv ====
// Operand forwarding select logic
module operand_forward (
	input  hazard_pkg::id_ex_ctl_t  id_ex,
	input  hazard_pkg::ex_mem_ctl_t ex_mem,
	input  hazard_pkg::mem_wb_ctl_t mem_wb,
	output hazard_pkg::fwd_sel_t    fwd
);

	import rv32i_pkg::*;
	import hazard_pkg::*;

	// a later stage holds a fresh value for src
	// x0 never counts, its writes are discarded
	function automatic logic writes_src(
		input logic     load_regfile,
		input reg_idx_t rd,
		input reg_idx_t src_idx
	);
		return load_regfile && (rd != zero_reg) && (rd == src_idx);
	endfunction

	// EX/MEM is younger, so it wins over MEM/WB
	function automatic fwd_src_t pick_src(input reg_idx_t src_idx);
		fwd_src_t sel;
		sel = from_regfile;
		if (writes_src(ex_mem.load_regfile, ex_mem.rd, src_idx)) begin
			sel = from_ex_mem;
		end else if (writes_src(mem_wb.load_regfile, mem_wb.rd, src_idx)) begin
			sel = from_mem_wb;
		end
		return sel;
	endfunction

	logic store_hit;

	// store in MEM needs the value MEM/WB is writing back
	assign store_hit = ex_mem.mem_write &&
		writes_src(mem_wb.load_regfile, mem_wb.rd, ex_mem.rs2);

	always_comb begin
		fwd.rs1_sel   = pick_src(id_ex.rs1);
		fwd.rs2_sel   = pick_src(id_ex.rs2);
		// store data taps only the writeback path
		fwd.wdata_sel = store_hit ? wdata_mem_wb : wdata_regfile;
	end

endmodule : operand_forward

// ==== hdl/rv32i_pkg.sv ====
// RV32I instruction encoding
package rv32i_pkg;

	// register file addressing
	localparam int reg_idx_w = 5;

	// index of the hardwired zero register
	localparam logic [reg_idx_w-1:0] zero_reg = '0;

	typedef logic [reg_idx_w-1:0] reg_idx_t;

	// major opcodes, bits [6:0] of every word
	typedef enum logic [6:0] {
		op_reg    = 7'b0110011,
		op_imm    = 7'b0010011,
		op_load   = 7'b0000011,
		op_store  = 7'b0100011,
		op_branch = 7'b1100011,
		op_jal    = 7'b1101111,
		op_jalr   = 7'b1100111,
		op_lui    = 7'b0110111,
		op_auipc  = 7'b0010111
	} opcode_t;

	// R-type layout
	// i, b, u and j formats share its rd, rs1 and funct3 slots
	typedef struct packed {
		logic [6:0] funct7;
		reg_idx_t   rs2;
		reg_idx_t   rs1;
		logic [2:0] funct3;
		reg_idx_t   rd;
		opcode_t    opcode;
	} r_fields_t;

	// S-type layout
	// the rd slot carries imm[4:0] here
	typedef struct packed {
		logic [6:0] imm_hi;
		reg_idx_t   rs2;
		reg_idx_t   rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		opcode_t    opcode;
	} s_fields_t;

	// one 32-bit word, two views
	// the opcode picks which view is meaningful
	typedef union packed {
		r_fields_t r;
		s_fields_t s;
	} instr_t;

endpackage : rv32i_pkg

// ==== hdl/stall_control.sv ====
// Per-stage stall vector
module stall_control (
	input  hazard_pkg::stall_cause_t cause,
	output hazard_pkg::stall_vec_t   stall
);

	// front end holds for any cause
	logic hold_front;
	// back end holds only for memory
	logic hold_back;
	logic insert_bubble;

	assign hold_front = cause.mem_stall | cause.load_use;
	assign hold_back  = cause.mem_stall;

	// frozen ID/EX keeps its instruction
	// a bubble would overwrite it, so memory wins
	assign insert_bubble = cause.load_use & ~cause.mem_stall;

	always_comb begin
		// pc and IF/ID re-present the dependent instruction
		stall.pc         = hold_front;
		stall.if_id      = hold_front;
		// remaining stages move unless memory is waiting
		stall.id_ex      = hold_back;
		stall.ex_mem     = hold_back;
		stall.mem_wb     = hold_back;
		stall.bubble     = insert_bubble;
		// fetch side keeps its request asserted on this
		stall.inst_stall = cause.inst_stall;
	end

endmodule : stall_control

// ==== hdl/stall_detect.sv ====
// Stall cause detection
module stall_detect (
	input  logic                   clk,
	input  logic                   rst_n,
	input  hazard_pkg::src_use_t   src,
	input  hazard_pkg::id_ex_ctl_t id_ex,
	input  hazard_pkg::mem_port_t  mem,
	output hazard_pkg::stall_cause_t cause
);

	import rv32i_pkg::*;

	// data strobes seen one cycle back
	logic data_read_q;
	logic data_write_q;
	// request still held in its second cycle
	logic read_held;
	logic write_held;
	logic data_wait;
	logic inst_wait;
	// load destination against IF/ID sources
	logic load_live;
	logic hit_rs1;
	logic hit_rs2;

	// pipelined data memory answers in two cycles
	// first cycle of a request never stalls
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			data_read_q  <= 1'b0;
			data_write_q <= 1'b0;
		end else begin
			data_read_q  <= mem.data_read;
			data_write_q <= mem.data_write;
		end
	end

	// masked by the live strobe, so a dropped request does not stall
	assign read_held  = data_read_q & mem.data_read;
	assign write_held = data_write_q & mem.data_write;
	assign data_wait  = (read_held | write_held) & ~mem.data_resp;

	// fetch outstanding without answer
	assign inst_wait = mem.inst_read & ~mem.inst_resp;

	// load in EX whose result is not ready yet
	assign load_live = id_ex.mem_read && (id_ex.rd != zero_reg);
	assign hit_rs1   = load_live && src.rs1_used && (id_ex.rd == src.rs1);
	assign hit_rs2   = load_live && src.rs2_used && (id_ex.rd == src.rs2);

	always_comb begin
		cause.inst_stall = inst_wait;
		cause.mem_stall  = inst_wait | data_wait;
		// store data reaching only through rs2 is caught by MEM/WB forwarding
		cause.load_use   = hit_rs1 | (hit_rs2 & ~src.is_store);
	end

endmodule : stall_detect
